// File: rtl/riscvIsaPkg.sv
package riscvIsaPkg;

   typedef logic [31:0] wordT;
   typedef logic [4:0]  regAddrT;

   // major opcodes
   localparam logic [6:0] opLui    = 7'b0110111;
   localparam logic [6:0] opJal    = 7'b1101111;
   localparam logic [6:0] opJalr   = 7'b1100111;
   localparam logic [6:0] opBranch = 7'b1100011;
   localparam logic [6:0] opLoad   = 7'b0000011;
   localparam logic [6:0] opStore  = 7'b0100011;
   localparam logic [6:0] opImm    = 7'b0010011;
   localparam logic [6:0] opReg    = 7'b0110011;
   localparam logic [6:0] opSystem = 7'b1110011;

   // branch conditions
   localparam logic [2:0] f3Beq = 3'b000;
   localparam logic [2:0] f3Bne = 3'b001;
   localparam logic [2:0] f3Blt = 3'b100;

   // alu funct3, shared by register and immediate forms
   localparam logic [2:0] f3AddSub = 3'b000;
   localparam logic [2:0] f3Sll    = 3'b001;
   localparam logic [2:0] f3Slt    = 3'b010;
   localparam logic [2:0] f3Xor    = 3'b100;
   localparam logic [2:0] f3SrlSra = 3'b101;   // funct7 bit 5 picks sra
   localparam logic [2:0] f3Or     = 3'b110;
   localparam logic [2:0] f3And    = 3'b111;

   localparam wordT instrEbreak = 32'h0010_0073;

   typedef enum logic [3:0] {
      aluAdd   = 4'd0,
      aluSub   = 4'd1,
      aluSll   = 4'd2,
      aluSlt   = 4'd3,
      aluXor   = 4'd4,
      aluSrl   = 4'd5,
      aluSra   = 4'd6,
      aluOr    = 4'd7,
      aluAnd   = 4'd8,
      aluPassB = 4'd9    // lui, immediate straight through
   } aluOpT;

endpackage

// File: rtl/riscvCorePkg.sv
package riscvCorePkg;

   localparam int iAddrBits = 12;   // instruction byte address
   localparam int dAddrBits = 12;   // data word address

   // first fetch after reset
   localparam logic [iAddrBits-1:0] resetPc = '0;

   // where an execute operand comes from
   typedef enum logic [1:0] {
      fwdNone  = 2'd0,   // register file value from decode
      fwdExMem = 2'd1,
      fwdMemWb = 2'd2
   } fwdSelT;

   // writeback value source
   typedef enum logic [1:0] {
      wbAlu  = 2'd0,
      wbMem  = 2'd1,
      wbLink = 2'd2      // pc + 4 of jal / jalr
   } wbSelT;

endpackage

// File: rtl/instrDecode.sv
`timescale 1ns/10ps

module instrDecode (
   input  riscvIsaPkg::wordT    instr,
   output riscvIsaPkg::regAddrT rs1,
   output riscvIsaPkg::regAddrT rs2,
   output riscvIsaPkg::regAddrT rd,
   output riscvIsaPkg::wordT    imm,
   output riscvIsaPkg::aluOpT   aluOp,
   output logic                 srcAPc,
   output logic                 srcBImm,
   output logic                 isBranch,
   output logic                 isJal,
   output logic                 isJalr,
   output logic                 memRead,
   output logic                 memWrite,
   output logic                 regWrite,
   output logic                 isHalt,
   output logic [2:0]           branchFunct,
   output riscvCorePkg::wbSelT  wbSel
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic       altFn;      // funct7 bit 5
   logic       writesRd;
   logic       known;
   riscvIsaPkg::wordT immI;

   function automatic riscvIsaPkg::aluOpT aluFromFunct(logic [2:0] f3, logic alt, logic isReg);
      case (f3)
         riscvIsaPkg::f3AddSub: return (isReg && alt) ? riscvIsaPkg::aluSub : riscvIsaPkg::aluAdd;
         riscvIsaPkg::f3Sll:    return riscvIsaPkg::aluSll;
         riscvIsaPkg::f3Slt:    return riscvIsaPkg::aluSlt;
         riscvIsaPkg::f3Xor:    return riscvIsaPkg::aluXor;
         riscvIsaPkg::f3SrlSra: return alt ? riscvIsaPkg::aluSra : riscvIsaPkg::aluSrl;
         riscvIsaPkg::f3Or:     return riscvIsaPkg::aluOr;
         riscvIsaPkg::f3And:    return riscvIsaPkg::aluAnd;
         default:               return riscvIsaPkg::aluAdd;
      endcase
   endfunction

   assign opcode      = instr[6:0];
   assign funct3      = instr[14:12];
   assign altFn       = instr[30];
   assign rd          = instr[11:7];
   assign branchFunct = funct3;
   assign immI        = {{20{instr[31]}}, instr[31:20]};
   assign regWrite    = writesRd && (rd != '0);   // x0 writes dropped here

   always_comb begin
      rs1      = instr[19:15];
      rs2      = '0;          // only set when the format really reads rs2
      imm      = immI;
      aluOp    = riscvIsaPkg::aluAdd;
      srcAPc   = 1'b0;
      srcBImm  = 1'b1;
      isBranch = 1'b0;
      isJal    = 1'b0;
      isJalr   = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      writesRd = 1'b0;
      isHalt   = 1'b0;
      known    = 1'b1;
      wbSel    = riscvCorePkg::wbAlu;
      case (opcode)
         riscvIsaPkg::opLui: begin
            rs1      = '0;
            imm      = {instr[31:12], 12'd0};
            aluOp    = riscvIsaPkg::aluPassB;
            writesRd = 1'b1;
         end
         riscvIsaPkg::opJal: begin
            rs1      = '0;
            imm      = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            srcAPc   = 1'b1;   // alu forms the target
            isJal    = 1'b1;
            writesRd = 1'b1;
            wbSel    = riscvCorePkg::wbLink;
         end
         riscvIsaPkg::opJalr: begin
            isJalr   = 1'b1;
            writesRd = 1'b1;
            wbSel    = riscvCorePkg::wbLink;
         end
         riscvIsaPkg::opBranch: begin
            rs2      = instr[24:20];
            imm      = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            srcAPc   = 1'b1;
            isBranch = 1'b1;
         end
         riscvIsaPkg::opLoad: begin
            memRead  = 1'b1;
            writesRd = 1'b1;
            wbSel    = riscvCorePkg::wbMem;
         end
         riscvIsaPkg::opStore: begin
            rs2      = instr[24:20];
            imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            memWrite = 1'b1;
         end
         riscvIsaPkg::opImm: begin
            aluOp    = aluFromFunct(funct3, altFn, 1'b0);
            writesRd = 1'b1;
         end
         riscvIsaPkg::opReg: begin
            rs2      = instr[24:20];
            srcBImm  = 1'b0;
            aluOp    = aluFromFunct(funct3, altFn, 1'b1);
            writesRd = 1'b1;
         end
         riscvIsaPkg::opSystem: begin
            rs1    = '0;
            isHalt = (instr == riscvIsaPkg::instrEbreak);
            known  = isHalt;   // no csr support
         end
         default: begin
            rs1   = '0;
            known = 1'b0;
         end
      endcase
   end

   // an all-zero word is what the top feeds in for a bubble
   unknownOpcode: assert final ($isunknown(instr) || instr == '0 || known)
      else $error("unrecognized instruction %h", instr);

endmodule

// File: rtl/forwardUnit.sv
`timescale 1ns/10ps

module forwardUnit (
   input  riscvIsaPkg::regAddrT exRs1,
   input  riscvIsaPkg::regAddrT exRs2,
   input  riscvIsaPkg::regAddrT exMemRd,
   input  riscvIsaPkg::regAddrT memWbRd,
   input  riscvIsaPkg::regAddrT idRs1,
   input  riscvIsaPkg::regAddrT idRs2,
   input  riscvIsaPkg::regAddrT idExRd,
   input  logic                 exMemRegWrite,
   input  logic                 memWbRegWrite,
   input  logic                 idExMemRead,
   output riscvCorePkg::fwdSelT fwdA,
   output riscvCorePkg::fwdSelT fwdB,
   output logic                 bypassA,
   output logic                 bypassB,
   output logic                 loadStall
);

   // youngest producer wins
   function automatic riscvCorePkg::fwdSelT pickSource(riscvIsaPkg::regAddrT rs);
      if (rs == '0)
         return riscvCorePkg::fwdNone;
      if (exMemRegWrite && exMemRd == rs)
         return riscvCorePkg::fwdExMem;
      if (memWbRegWrite && memWbRd == rs)
         return riscvCorePkg::fwdMemWb;
      return riscvCorePkg::fwdNone;
   endfunction

   assign fwdA = pickSource(exRs1);
   assign fwdB = pickSource(exRs2);

   // distance three, register file is written in the same cycle it is read
   assign bypassA = memWbRegWrite && idRs1 != '0 && memWbRd == idRs1;
   assign bypassB = memWbRegWrite && idRs2 != '0 && memWbRd == idRs2;

   assign loadStall = idExMemRead && idExRd != '0 &&
                      (idExRd == idRs1 || idExRd == idRs2);

endmodule

// File: rtl/aluExec.sv
`timescale 1ns/10ps

module aluExec (
   input  riscvIsaPkg::wordT                  rs1Val,
   input  riscvIsaPkg::wordT                  rs2Val,
   input  riscvIsaPkg::wordT                  exMemAlu,
   input  riscvIsaPkg::wordT                  wbVal,
   input  riscvIsaPkg::wordT                  imm,
   input  logic [riscvCorePkg::iAddrBits-1:0] pc,
   input  riscvCorePkg::fwdSelT               fwdA,
   input  riscvCorePkg::fwdSelT               fwdB,
   input  logic                               srcAPc,
   input  logic                               srcBImm,
   input  logic                               isBranch,
   input  logic                               isJal,
   input  logic                               isJalr,
   input  riscvIsaPkg::aluOpT                 aluOp,
   input  logic [2:0]                         branchFunct,
   output riscvIsaPkg::wordT                  aluOut,
   output riscvIsaPkg::wordT                  storeData,
   output logic                               redirect,
   output logic [riscvCorePkg::iAddrBits-1:0] target
);

   riscvIsaPkg::wordT regA, regB, opA, opB;
   logic taken;

   always_comb begin
      case (fwdA)
         riscvCorePkg::fwdExMem: regA = exMemAlu;
         riscvCorePkg::fwdMemWb: regA = wbVal;
         default:                regA = rs1Val;
      endcase
      case (fwdB)
         riscvCorePkg::fwdExMem: regB = exMemAlu;
         riscvCorePkg::fwdMemWb: regB = wbVal;
         default:                regB = rs2Val;
      endcase
   end

   assign storeData = regB;
   assign opA = srcAPc ? riscvIsaPkg::wordT'(pc) : regA;
   assign opB = srcBImm ? imm : regB;

   always_comb begin
      case (aluOp)
         riscvIsaPkg::aluSub:   aluOut = opA - opB;
         riscvIsaPkg::aluSll:   aluOut = opA << opB[4:0];
         riscvIsaPkg::aluSlt:   aluOut = {31'd0, $signed(opA) < $signed(opB)};
         riscvIsaPkg::aluXor:   aluOut = opA ^ opB;
         riscvIsaPkg::aluSrl:   aluOut = opA >> opB[4:0];
         riscvIsaPkg::aluSra:   aluOut = $signed(opA) >>> opB[4:0];
         riscvIsaPkg::aluOr:    aluOut = opA | opB;
         riscvIsaPkg::aluAnd:   aluOut = opA & opB;
         riscvIsaPkg::aluPassB: aluOut = opB;
         default:               aluOut = opA + opB;
      endcase
   end

   // compares run on forwarded registers, the alu is busy with the target
   always_comb begin
      case (branchFunct)
         riscvIsaPkg::f3Beq: taken = (regA == regB);
         riscvIsaPkg::f3Bne: taken = (regA != regB);
         riscvIsaPkg::f3Blt: taken = ($signed(regA) < $signed(regB));
         default:            taken = 1'b0;
      endcase
   end

   assign redirect = isJal || isJalr || (isBranch && taken);
   assign target   = {aluOut[riscvCorePkg::iAddrBits-1:1], 1'b0};   // clears jalr bit 0

endmodule

// File: rtl/riscvTop.sv
`timescale 1ns/10ps

module riscvTop (
   input  logic                               CLK,
   input  logic                               RSTn,
   // instruction memory
   output logic                               I_MEM_CSN,
   input  riscvIsaPkg::wordT                  I_MEM_DI,
   output logic [riscvCorePkg::iAddrBits-1:0] I_MEM_ADDR,   // byte address
   // data memory
   output logic                               D_MEM_CSN,
   input  riscvIsaPkg::wordT                  D_MEM_DI,
   output riscvIsaPkg::wordT                  D_MEM_DOUT,
   output logic [riscvCorePkg::dAddrBits-1:0] D_MEM_ADDR,   // word address
   output logic                               D_MEM_WEN,
   // register file
   output logic                               RF_WE,
   output riscvIsaPkg::regAddrT               RF_RA1,
   output riscvIsaPkg::regAddrT               RF_RA2,
   output riscvIsaPkg::regAddrT               RF_WA1,
   input  riscvIsaPkg::wordT                  RF_RD1,
   input  riscvIsaPkg::wordT                  RF_RD2,
   output riscvIsaPkg::wordT                  RF_WD,
   output logic                               HALT,
   output riscvIsaPkg::wordT                  NUM_INST,
   output riscvIsaPkg::wordT                  OUTPUT_PORT
);

   logic [riscvCorePkg::iAddrBits-1:0] pc, ifIdPc, idExPc, exMemLink, exTarget;
   logic ifIdValid, idExValid, exMemValid, memWbValid;
   logic fetchOff, haltQ, exHalt, flush, exRedirect;
   riscvIsaPkg::wordT ifIdInstr, decInstr;

   // decode outputs
   riscvIsaPkg::regAddrT decRs1, decRs2, decRd;
   riscvIsaPkg::wordT    decImm;
   riscvIsaPkg::aluOpT   decAluOp;
   logic decSrcAPc, decSrcBImm, decIsBranch, decIsJal, decIsJalr;
   logic decMemRead, decMemWrite, decRegWrite, decIsHalt;
   logic [2:0] decBranchFunct;
   riscvCorePkg::wbSelT  decWbSel;

   riscvCorePkg::fwdSelT fwdA, fwdB;
   logic bypassA, bypassB, loadStall;

   // id/ex
   riscvIsaPkg::wordT    idExRs1Val, idExRs2Val, idExImm;
   riscvIsaPkg::regAddrT idExRs1, idExRs2, idExRd;
   riscvIsaPkg::aluOpT   idExAluOp;
   logic idExSrcAPc, idExSrcBImm, idExIsBranch, idExIsJal, idExIsJalr;
   logic idExMemRead, idExMemWrite, idExRegWrite, idExIsHalt;
   logic [2:0] idExBranchFunct;
   riscvCorePkg::wbSelT  idExWbSel;
   riscvIsaPkg::wordT    exAluOut, exStoreData;

   // ex/mem and mem/wb
   riscvIsaPkg::wordT    exMemAlu, exMemStoreData, memResult, memWbVal;
   riscvIsaPkg::regAddrT exMemRd, memWbRd;
   logic exMemMemRead, exMemMemWrite, exMemRegWrite, exMemIsHalt;
   riscvCorePkg::wbSelT  exMemWbSel;
   logic memWbRegWrite, memWbIsHalt;

   assign exHalt = idExValid && idExIsHalt;
   assign flush  = exRedirect || exHalt;   // squash the two younger slots

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc <= riscvCorePkg::resetPc;
      end else if (exRedirect) begin
         pc <= exTarget;
      end else if (!loadStall && !fetchOff) begin
         pc <= pc + riscvCorePkg::iAddrBits'(4);
      end
   end

   always_ff @(posedge CLK) begin
      if (RSTn || flush || fetchOff) begin
         ifIdValid <= 1'b0;
      end else if (!loadStall) begin
         ifIdValid <= 1'b1;
      end
   end

   always_ff @(posedge CLK) begin
      if (!loadStall) begin   // held during a load-use stall
         ifIdInstr <= I_MEM_DI;
         ifIdPc    <= pc;
      end
   end

   assign decInstr = ifIdValid ? ifIdInstr : '0;   // bubble decodes to nothing

   instrDecode dec_i (
      .instr       (decInstr),
      .rs1         (decRs1),
      .rs2         (decRs2),
      .rd          (decRd),
      .imm         (decImm),
      .aluOp       (decAluOp),
      .srcAPc      (decSrcAPc),
      .srcBImm     (decSrcBImm),
      .isBranch    (decIsBranch),
      .isJal       (decIsJal),
      .isJalr      (decIsJalr),
      .memRead     (decMemRead),
      .memWrite    (decMemWrite),
      .regWrite    (decRegWrite),
      .isHalt      (decIsHalt),
      .branchFunct (decBranchFunct),
      .wbSel       (decWbSel)
   );

   forwardUnit fwd_i (
      .exRs1         (idExRs1),
      .exRs2         (idExRs2),
      .exMemRd       (exMemRd),
      .memWbRd       (memWbRd),
      .idRs1         (decRs1),
      .idRs2         (decRs2),
      .idExRd        (idExRd),
      .exMemRegWrite (exMemValid && exMemRegWrite),
      .memWbRegWrite (RF_WE),
      .idExMemRead   (idExValid && idExMemRead),
      .fwdA          (fwdA),
      .fwdB          (fwdB),
      .bypassA       (bypassA),
      .bypassB       (bypassB),
      .loadStall     (loadStall)
   );

   always_ff @(posedge CLK) begin
      if (RSTn || flush || loadStall) idExValid <= 1'b0;
      else idExValid <= ifIdValid;
   end

   always_ff @(posedge CLK) begin
      idExPc          <= ifIdPc;
      idExRs1Val      <= bypassA ? RF_WD : RF_RD1;
      idExRs2Val      <= bypassB ? RF_WD : RF_RD2;
      idExImm         <= decImm;
      idExRs1         <= decRs1;
      idExRs2         <= decRs2;
      idExRd          <= decRd;
      idExAluOp       <= decAluOp;
      idExSrcAPc      <= decSrcAPc;
      idExSrcBImm     <= decSrcBImm;
      idExIsBranch    <= decIsBranch;
      idExIsJal       <= decIsJal;
      idExIsJalr      <= decIsJalr;
      idExMemRead     <= decMemRead;
      idExMemWrite    <= decMemWrite;
      idExRegWrite    <= decRegWrite;
      idExIsHalt      <= decIsHalt;
      idExBranchFunct <= decBranchFunct;
      idExWbSel       <= decWbSel;
   end

   aluExec alu_i (
      .rs1Val      (idExRs1Val),
      .rs2Val      (idExRs2Val),
      .exMemAlu    (memResult),   // never a load here, the stall sees to that
      .wbVal       (RF_WD),
      .imm         (idExImm),
      .pc          (idExPc),
      .fwdA        (fwdA),
      .fwdB        (fwdB),
      .srcAPc      (idExSrcAPc),
      .srcBImm     (idExSrcBImm),
      .isBranch    (idExValid && idExIsBranch),
      .isJal       (idExValid && idExIsJal),
      .isJalr      (idExValid && idExIsJalr),
      .aluOp       (idExAluOp),
      .branchFunct (idExBranchFunct),
      .aluOut      (exAluOut),
      .storeData   (exStoreData),
      .redirect    (exRedirect),
      .target      (exTarget)
   );

   always_ff @(posedge CLK) begin
      exMemValid     <= RSTn ? 1'b0 : idExValid;
      exMemAlu       <= exAluOut;
      exMemStoreData <= exStoreData;
      exMemLink      <= idExPc + riscvCorePkg::iAddrBits'(4);
      exMemRd        <= idExRd;
      exMemMemRead   <= idExMemRead;
      exMemMemWrite  <= idExMemWrite;
      exMemRegWrite  <= idExRegWrite;
      exMemIsHalt    <= idExIsHalt;
      exMemWbSel     <= idExWbSel;
   end

   always_comb begin
      case (exMemWbSel)
         riscvCorePkg::wbMem:  memResult = D_MEM_DI;
         riscvCorePkg::wbLink: memResult = riscvIsaPkg::wordT'(exMemLink);
         default:              memResult = exMemAlu;
      endcase
   end

   always_ff @(posedge CLK) begin
      memWbValid    <= RSTn ? 1'b0 : exMemValid;
      memWbVal      <= memResult;
      memWbRd       <= exMemRd;
      memWbRegWrite <= exMemRegWrite;
      memWbIsHalt   <= exMemIsHalt;
   end

   // retire bookkeeping
   always_ff @(posedge CLK) begin
      if (RSTn) begin
         fetchOff <= 1'b0;
         haltQ    <= 1'b0;
         NUM_INST <= '0;
      end else begin
         if (exHalt) fetchOff <= 1'b1;   // ebreak in execute, stop fetching
         if (memWbValid && memWbIsHalt) haltQ <= 1'b1;
         if (memWbValid) NUM_INST <= NUM_INST + 32'd1;
      end
   end

   assign I_MEM_ADDR  = pc;
   assign I_MEM_CSN   = RSTn || fetchOff;
   assign RF_RA1      = decRs1;
   assign RF_RA2      = decRs2;
   assign D_MEM_CSN   = !(exMemValid && (exMemMemRead || exMemMemWrite));
   assign D_MEM_WEN   = !(exMemValid && exMemMemWrite);
   assign D_MEM_ADDR  = exMemAlu[riscvCorePkg::dAddrBits+1:2];
   assign D_MEM_DOUT  = exMemStoreData;
   assign RF_WE       = memWbValid && memWbRegWrite;
   assign RF_WA1      = memWbRd;
   assign RF_WD       = memWbVal;
   assign OUTPUT_PORT = RF_WD;
   assign HALT        = haltQ;

   // nothing may retire once halted
   countFrozen: assert property (@(posedge CLK) disable iff (RSTn)
      HALT |=> $stable(NUM_INST));

endmodule

// File: tests/tbClock.sv
`timescale 1ns/10ps

module tbClock (
   output logic CLK,
   output logic RSTn
);

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;   // 8 ns period
   end

   // reset held for two rising edges, released on a falling edge
   initial begin
      RSTn = 1'b1;
      repeat (2) @(posedge CLK);
      @(negedge CLK);
      RSTn = 1'b0;
   end

endmodule

// File: tests/tbMemModel.sv
`timescale 1ns/10ps

module tbMemModel (
   input  logic                 CLK,
   input  logic                 I_MEM_CSN,
   input  logic [11:0]          I_MEM_ADDR,
   output riscvIsaPkg::wordT    I_MEM_DI,
   input  logic                 D_MEM_CSN,
   input  logic                 D_MEM_WEN,
   input  logic [11:0]          D_MEM_ADDR,
   input  riscvIsaPkg::wordT    D_MEM_DOUT,
   output riscvIsaPkg::wordT    D_MEM_DI,
   input  logic                 RF_WE,
   input  riscvIsaPkg::regAddrT RF_RA1,
   input  riscvIsaPkg::regAddrT RF_RA2,
   input  riscvIsaPkg::regAddrT RF_WA1,
   input  riscvIsaPkg::wordT    RF_WD,
   output riscvIsaPkg::wordT    RF_RD1,
   output riscvIsaPkg::wordT    RF_RD2
);

   riscvIsaPkg::wordT imem [0:1023];
   riscvIsaPkg::wordT dmem [0:4095];
   riscvIsaPkg::wordT regs [0:31];

   initial begin
      for (int i = 0; i < 1024; i++) begin
         imem[i] = {12'(i), 20'h0_0013};   // addi x0, x0, i
      end
      for (int i = 0; i < 4096; i++) begin
         dmem[i] = 32'hA500_0000 | i;   // pattern tied to the word address
      end
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
   end

   // fetch is word aligned
   assign I_MEM_DI = I_MEM_CSN ? '0 : imem[I_MEM_ADDR[11:2]];
   assign D_MEM_DI = dmem[D_MEM_ADDR];

   assign RF_RD1 = (RF_RA1 == '0) ? '0 : regs[RF_RA1];
   assign RF_RD2 = (RF_RA2 == '0) ? '0 : regs[RF_RA2];

   always @(posedge CLK) begin
      if (!D_MEM_CSN && !D_MEM_WEN) begin
         dmem[D_MEM_ADDR] <= D_MEM_DOUT;
      end
      if (RF_WE && RF_WA1 != '0) begin
         regs[RF_WA1] <= RF_WD;
      end
   end

endmodule

// File: tests/riscvTopTb.sv
`timescale 1ns/10ps

module riscvTopTb;

   logic CLK, RSTn;
   logic I_MEM_CSN, D_MEM_CSN, D_MEM_WEN, RF_WE, HALT;
   logic [11:0] I_MEM_ADDR, D_MEM_ADDR;
   riscvIsaPkg::wordT I_MEM_DI, D_MEM_DI, D_MEM_DOUT, RF_RD1, RF_RD2, RF_WD;
   riscvIsaPkg::wordT NUM_INST, OUTPUT_PORT;
   riscvIsaPkg::regAddrT RF_RA1, RF_RA2, RF_WA1;

   // expected retirement table, kind 0 reg write, 1 store, 2 nothing
   int                   rowKind [$];
   riscvIsaPkg::regAddrT rowRd [$];
   riscvIsaPkg::wordT    rowVal [$];
   riscvIsaPkg::wordT    rowAddr [$];
   riscvIsaPkg::wordT    storeAddrQ [$];
   riscvIsaPkg::wordT    storeDataQ [$];
   int                   loadPc;
   int                   cycles;
   int                   cycleLimit;

   tbClock clk_i (.CLK(CLK), .RSTn(RSTn));

   tbMemModel mem_i (
      .CLK(CLK), .I_MEM_CSN(I_MEM_CSN), .I_MEM_ADDR(I_MEM_ADDR), .I_MEM_DI(I_MEM_DI),
      .D_MEM_CSN(D_MEM_CSN), .D_MEM_WEN(D_MEM_WEN), .D_MEM_ADDR(D_MEM_ADDR),
      .D_MEM_DOUT(D_MEM_DOUT), .D_MEM_DI(D_MEM_DI), .RF_WE(RF_WE), .RF_RA1(RF_RA1),
      .RF_RA2(RF_RA2), .RF_WA1(RF_WA1), .RF_WD(RF_WD), .RF_RD1(RF_RD1), .RF_RD2(RF_RD2)
   );

   riscvTop dut_i (
      .CLK(CLK), .RSTn(RSTn), .I_MEM_CSN(I_MEM_CSN), .I_MEM_DI(I_MEM_DI),
      .I_MEM_ADDR(I_MEM_ADDR), .D_MEM_CSN(D_MEM_CSN), .D_MEM_DI(D_MEM_DI),
      .D_MEM_DOUT(D_MEM_DOUT), .D_MEM_ADDR(D_MEM_ADDR), .D_MEM_WEN(D_MEM_WEN),
      .RF_WE(RF_WE), .RF_RA1(RF_RA1), .RF_RA2(RF_RA2), .RF_WA1(RF_WA1),
      .RF_RD1(RF_RD1), .RF_RD2(RF_RD2), .RF_WD(RF_WD), .HALT(HALT),
      .NUM_INST(NUM_INST), .OUTPUT_PORT(OUTPUT_PORT)
   );

   task automatic stopOnError(string what);
      $display("%s", what);
      $display("Done: errors found");
      $fatal(1);
   endtask

   task automatic checkWord(string name, riscvIsaPkg::wordT got, riscvIsaPkg::wordT exp);
      if (got !== exp) begin
         $display("CHECK FAILED time %0t %s got %h expected %h", $time, name, got, exp);
         stopOnError("wrong word value");
      end
   endtask

   task automatic checkReg(string name, riscvIsaPkg::regAddrT got,
                           riscvIsaPkg::regAddrT exp);
      if (got !== exp) begin
         $display("CHECK FAILED time %0t %s got %0d expected %0d", $time, name, got, exp);
         stopOnError("wrong register index");
      end
   endtask

   task automatic checkBit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED time %0t %s got %b expected %b", $time, name, got, exp);
         stopOnError("wrong control bit");
      end
   endtask

   // small assembler helpers
   function automatic riscvIsaPkg::wordT encI(logic [6:0] op, logic [2:0] f3, int rd,
                                              int rs1, int imm);
      logic [11:0] i12;
      i12 = imm[11:0];
      return {i12, 5'(rs1), f3, 5'(rd), op};
   endfunction

   function automatic riscvIsaPkg::wordT encR(logic [6:0] f7, logic [2:0] f3, int rd,
                                              int rs1, int rs2);
      return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), riscvIsaPkg::opReg};
   endfunction

   function automatic riscvIsaPkg::wordT encS(int rs2, int rs1, int imm);
      logic [11:0] i12;
      i12 = imm[11:0];
      return {i12[11:5], 5'(rs2), 5'(rs1), 3'b010, i12[4:0], riscvIsaPkg::opStore};
   endfunction

   function automatic riscvIsaPkg::wordT encB(logic [2:0] f3, int rs1, int rs2, int imm);
      logic [12:0] i13;
      i13 = imm[12:0];
      return {i13[12], i13[10:5], 5'(rs2), 5'(rs1), f3, i13[4:1], i13[11],
              riscvIsaPkg::opBranch};
   endfunction

   function automatic riscvIsaPkg::wordT encJ(int rd, int imm);
      logic [20:0] i21;
      i21 = imm[20:0];
      return {i21[20], i21[10:1], i21[11], i21[19:12], 5'(rd), riscvIsaPkg::opJal};
   endfunction

   // place one instruction, and its expected retirement unless it is skipped
   task automatic emit(riscvIsaPkg::wordT instr, int kind, int rd, riscvIsaPkg::wordT val,
                       riscvIsaPkg::wordT addr, bit skipped);
      mem_i.imem[loadPc >> 2] = instr;
      loadPc += 4;
      if (!skipped) begin
         rowKind.push_back(kind);
         rowRd.push_back(5'(rd));
         rowVal.push_back(val);
         rowAddr.push_back(addr);
      end
   endtask

   task automatic loadProgram();
      logic [6:0] opI;
      logic [6:0] sra;
      opI = riscvIsaPkg::opImm;
      sra = 7'b0100000;
      loadPc = 0;
      emit({20'h12345, 5'd1, riscvIsaPkg::opLui}, 0, 1, 32'h1234_5000, 0, 0);
      emit(encI(opI, 3'b000, 2, 0, 5), 0, 2, 5, 0, 0);
      emit(encI(opI, 3'b000, 3, 2, -3), 0, 3, 2, 0, 0);              // distance one
      emit(encR(7'd0, 3'b000, 4, 2, 3), 0, 4, 7, 0, 0);               // distance one and two
      emit(encR(sra, 3'b000, 5, 4, 2), 0, 5, 2, 0, 0);                // x2 at distance three
      emit(encR(7'd0, 3'b001, 6, 2, 3), 0, 6, 20, 0, 0);
      emit(encR(7'd0, 3'b010, 7, 5, 4), 0, 7, 1, 0, 0);
      emit(encR(7'd0, 3'b100, 8, 4, 2), 0, 8, 2, 0, 0);
      emit(encR(7'd0, 3'b101, 9, 1, 3), 0, 9, 32'h048D_1400, 0, 0);
      emit(encI(opI, 3'b000, 10, 0, -16), 0, 10, 32'hFFFF_FFF0, 0, 0);
      emit(encR(sra, 3'b101, 11, 10, 3), 0, 11, 32'hFFFF_FFFC, 0, 0);
      emit(encR(7'd0, 3'b110, 12, 4, 6), 0, 12, 23, 0, 0);
      emit(encR(7'd0, 3'b111, 13, 4, 8), 0, 13, 2, 0, 0);
      emit(encI(opI, 3'b010, 14, 10, -1), 0, 14, 1, 0, 0);
      emit(encI(opI, 3'b100, 15, 4, 255), 0, 15, 32'hF8, 0, 0);
      emit(encI(opI, 3'b110, 16, 2, 32'h30), 0, 16, 32'h35, 0, 0);
      emit(encI(opI, 3'b111, 17, 12, 32'h1C), 0, 17, 32'h14, 0, 0);
      emit(encI(opI, 3'b001, 18, 2, 4), 0, 18, 32'h50, 0, 0);
      emit(encI(opI, 3'b101, 19, 10, 28), 0, 19, 32'hF, 0, 0);
      emit(encI(opI, 3'b101, 20, 10, 32'h402), 0, 20, 32'hFFFF_FFFC, 0, 0);  // srai
      emit(encI(opI, 3'b000, 21, 0, 64), 0, 21, 64, 0, 0);
      emit(encI(opI, 3'b000, 22, 4, 100), 0, 22, 107, 0, 0);
      emit(encS(22, 21, 4), 1, 0, 107, 17, 0);                         // word address 17
      emit(encI(riscvIsaPkg::opLoad, 3'b010, 23, 21, 4), 0, 23, 107, 0, 0);
      emit(encR(7'd0, 3'b000, 24, 23, 2), 0, 24, 112, 0, 0);          // load use
      emit(encB(riscvIsaPkg::f3Beq, 24, 24, 12), 2, 0, 0, 0, 0);
      emit(encI(opI, 3'b000, 25, 0, 1), 0, 25, 1, 0, 1);
      emit(encI(opI, 3'b000, 25, 0, 2), 0, 25, 2, 0, 1);
      emit(encB(riscvIsaPkg::f3Bne, 2, 3, 8), 2, 0, 0, 0, 0);
      emit(encI(opI, 3'b000, 25, 0, 3), 0, 25, 3, 0, 1);
      emit(encB(riscvIsaPkg::f3Blt, 10, 2, 8), 2, 0, 0, 0, 0);
      emit(encI(opI, 3'b000, 25, 0, 4), 0, 25, 4, 0, 1);
      emit(encB(riscvIsaPkg::f3Beq, 2, 3, 8), 2, 0, 0, 0, 0);         // falls through
      emit(encB(riscvIsaPkg::f3Bne, 2, 2, 8), 2, 0, 0, 0, 0);
      emit(encB(riscvIsaPkg::f3Blt, 2, 10, 8), 2, 0, 0, 0, 0);
      emit(encJ(26, 8), 0, 26, 144, 0, 0);                              // link is pc + 4
      emit(encI(opI, 3'b000, 25, 0, 5), 0, 25, 5, 0, 1);
      emit(encI(opI, 3'b000, 27, 0, 164), 0, 27, 164, 0, 0);
      emit(encI(riscvIsaPkg::opJalr, 3'b000, 28, 27, 0), 0, 28, 156, 0, 0);
      emit(encI(opI, 3'b000, 25, 0, 6), 0, 25, 6, 0, 1);
      emit(encI(opI, 3'b000, 25, 0, 7), 0, 25, 7, 0, 1);
      emit(encI(opI, 3'b000, 29, 28, 1), 0, 29, 157, 0, 0);
      emit(riscvIsaPkg::instrEbreak, 2, 0, 0, 0, 0);
   endtask

   task automatic checkResetState();
      checkBit("RF_WE", RF_WE, 1'b0);
      checkBit("HALT", HALT, 1'b0);
      checkWord("NUM_INST", NUM_INST, 32'd0);
      checkBit("D_MEM_WEN", D_MEM_WEN, 1'b1);
      checkBit("D_MEM_CSN", D_MEM_CSN, 1'b1);
   endtask

   // global watchdog
   always @(posedge CLK) begin
      cycles++;
      if (cycleLimit > 0 && cycles > cycleLimit) begin
         $display("timeout after %0d cycles, core did not finish the program", cycles);
         $display("Done: errors found");
         $fatal(1);
      end
   end

   initial begin
      logic              prevWe;
      riscvIsaPkg::regAddrT prevWa;
      riscvIsaPkg::wordT prevWd;
      riscvIsaPkg::wordT prevOut;
      riscvIsaPkg::wordT prevNum;
      int                row;
      cycles = 0;
      cycleLimit = 0;
      @(negedge CLK);   // program goes in over the default fill, before the first fetch
      loadProgram();
      cycleLimit = 3 * rowKind.size() + 20;

      #1;
      checkResetState();
      checkBit("I_MEM_CSN", I_MEM_CSN, 1'b1);   // no fetch while reset is held
      @(negedge CLK);
      #1;
      checkResetState();
      wait (RSTn == 1'b0);
      @(negedge CLK);
      #1;
      checkResetState();

      prevWe = RF_WE;
      prevWa = RF_WA1;
      prevWd = RF_WD;
      prevOut = OUTPUT_PORT;
      prevNum = NUM_INST;
      row = 0;
      while (row < rowKind.size()) begin
         @(negedge CLK);
         #1;
         if (!D_MEM_WEN) begin
            storeAddrQ.push_back(riscvIsaPkg::wordT'(D_MEM_ADDR));
            storeDataQ.push_back(D_MEM_DOUT);
         end
         if (NUM_INST !== prevNum) begin   // the writeback of last cycle retired
            checkWord("NUM_INST", NUM_INST, riscvIsaPkg::wordT'(row + 1));
            if (rowKind[row] == 0) begin
               checkBit("RF_WE", prevWe, 1'b1);
               checkReg("RF_WA1", prevWa, rowRd[row]);
               checkWord("RF_WD", prevWd, rowVal[row]);
               checkWord("OUTPUT_PORT", prevOut, rowVal[row]);
            end else begin
               checkBit("RF_WE", prevWe, 1'b0);
            end
            if (rowKind[row] == 1) begin
               if (storeAddrQ.size() == 0) begin
                  stopOnError("store retired without a data memory write");
               end
               checkWord("D_MEM_ADDR", storeAddrQ.pop_front(), rowAddr[row]);
               checkWord("D_MEM_DOUT", storeDataQ.pop_front(), rowVal[row]);
            end
            row++;
         end
         prevWe = RF_WE;
         prevWa = RF_WA1;
         prevWd = RF_WD;
         prevOut = OUTPUT_PORT;
         prevNum = NUM_INST;
      end

      if (storeAddrQ.size() != 0) begin
         stopOnError("data memory write seen with no store in the table");
      end
      checkWord("mem word 17", mem_i.dmem[17], 32'd107);

      checkBit("HALT", HALT, 1'b1);
      repeat (10) begin
         @(negedge CLK);
         #1;
         checkBit("HALT", HALT, 1'b1);
         checkBit("I_MEM_CSN", I_MEM_CSN, 1'b1);
         checkBit("RF_WE", RF_WE, 1'b0);
         checkWord("NUM_INST", NUM_INST, riscvIsaPkg::wordT'(rowKind.size()));
      end

      $display("Done: no errors");
      $finish;
   end

endmodule

// File: vlog.f
rtl/riscvIsaPkg.sv
rtl/riscvCorePkg.sv
rtl/instrDecode.sv
rtl/forwardUnit.sv
rtl/aluExec.sv
rtl/riscvTop.sv
tests/tbClock.sv
tests/tbMemModel.sv
tests/riscvTopTb.sv
